/* logic/irqc_pkg.sv */
// shared register map, widths and source numbering for the interrupt subsystem
package irqc_pkg;

  // bus and address width
  localparam int data_w = 16;

  // interrupt sources
  localparam int num_ext = 3;               // external event lines
  localparam int num_src = num_ext + 1;     // plus the interval timer
  localparam int flag_w  = num_src + 1;     // plus the user flag
  localparam int tmr_src = 3;               // timer flag bit

  // address block decode on the upper address bits
  localparam int blk_lsb = 4;
  localparam logic [data_w-blk_lsb-1:0] irqc_base = 12'h000;   // 16'h000x
  localparam logic [data_w-blk_lsb-1:0] tmr_base  = 12'h001;   // 16'h001x

  // timer control register width
  localparam int ctrl_w = 2;

  typedef enum logic [data_w-1:0] {
    reg_irqc_flag = 16'h0000,
    reg_irqc_user = 16'h0002,
    reg_irqc_mask = 16'h0004,
    reg_tmr_load  = 16'h0010,
    reg_tmr_ctrl  = 16'h0012,
    reg_tmr_count = 16'h0014
  } reg_addr_e;

  // bit positions in the timer control register
  typedef enum int unsigned {
    ctrl_en     = 0,
    ctrl_reload = 1
  } tmr_ctrl_bit_e;

endpackage

/* logic/event_sync.sv */
// two-flop synchronizer with rising-edge pulse for the external event lines
`timescale 1ns/1ps

module event_sync (
  input  logic                        wb_clk_i,
  input  logic                        wb_rst_i,
  input  logic [irqc_pkg::num_ext-1:0] ext_irq_i,
  output logic [irqc_pkg::num_ext-1:0] ext_evt_o
);

  logic [irqc_pkg::num_ext-1:0] sync_q0;
  logic [irqc_pkg::num_ext-1:0] sync_q1;
  logic [irqc_pkg::num_ext-1:0] edge_q;   // previous synced level

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      sync_q0 <= '0;
      sync_q1 <= '0;
      edge_q  <= '0;
    end else begin
      sync_q0 <= ext_irq_i;   // metastable stage
      sync_q1 <= sync_q0;
      edge_q  <= sync_q1;
    end
  end

  // one pulse per low to high transition
  assign ext_evt_o = sync_q1 & ~edge_q;

endmodule

/* logic/wb_decode.sv */
// Wishbone address decoder with a responder for unmapped addresses
`timescale 1ns/1ps

module wb_decode (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic [irqc_pkg::data_w-1:0] wb_adr_i,
  input  logic                       wb_ack_i,
  output logic                       irqc_sel_o,
  output logic                       tmr_sel_o,
  output logic                       nomap_ack_o
);

  logic acc;
  logic irqc_hit;
  logic tmr_hit;

  // new access only while no ack is on the bus
  assign acc = wb_cyc_i & wb_stb_i & ~wb_ack_i;

  assign irqc_hit = wb_adr_i[irqc_pkg::data_w-1:irqc_pkg::blk_lsb] == irqc_pkg::irqc_base;
  assign tmr_hit  = wb_adr_i[irqc_pkg::data_w-1:irqc_pkg::blk_lsb] == irqc_pkg::tmr_base;

  assign irqc_sel_o = acc & irqc_hit;
  assign tmr_sel_o  = acc & tmr_hit;

  // unmapped accesses still get an ack so the master never hangs
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      nomap_ack_o <= 1'b0;
    end else begin
      nomap_ack_o <= acc & ~irqc_hit & ~tmr_hit;
    end
  end

endmodule

/* logic/irq_controller.sv */
// interrupt controller with event flags, mask, user flag and interrupt output
`timescale 1ns/1ps

module irq_controller (
  input  logic                        wb_clk_i,
  input  logic                        wb_rst_i,
  input  logic                        sel_i,
  input  logic                        wb_we_i,
  input  logic [irqc_pkg::data_w-1:0]  wb_adr_i,
  input  logic [irqc_pkg::data_w-1:0]  wb_dat_i,
  input  logic [irqc_pkg::num_src-1:0] evt_i,
  output logic                        ack_o,
  output logic [irqc_pkg::data_w-1:0]  dat_o,
  output logic                        irq_o
);

  logic [irqc_pkg::flag_w-1:0] irq_flag;
  logic [irqc_pkg::flag_w-1:0] irq_mask;
  logic [irqc_pkg::flag_w-1:0] evt_set;   // events lined up with the flag bits
  logic                        wr;
  logic                        rd;
  irqc_pkg::reg_addr_e         adr;

  assign adr     = irqc_pkg::reg_addr_e'(wb_adr_i);
  assign evt_set = {1'b0, evt_i};
  assign wr      = sel_i & wb_we_i;
  assign rd      = sel_i & ~wb_we_i;

  // events set flags even during a bus write
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      irq_flag <= '0;
    end else if (wr && adr == irqc_pkg::reg_irqc_flag) begin
      irq_flag <= (irq_flag & wb_dat_i[irqc_pkg::flag_w-1:0]) | evt_set;  // zeros clear
    end else if (wr && adr == irqc_pkg::reg_irqc_user) begin
      irq_flag[irqc_pkg::num_src-1:0] <= irq_flag[irqc_pkg::num_src-1:0] | evt_i;
      irq_flag[irqc_pkg::num_src]     <= wb_dat_i == 16'hffff;
    end else begin
      irq_flag <= irq_flag | evt_set;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      irq_mask <= '1;   // everything enabled out of reset
    end else if (wr && adr == irqc_pkg::reg_irqc_mask) begin
      irq_mask <= wb_dat_i[irqc_pkg::flag_w-1:0];
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= sel_i;
    end
  end

  // read data valid in the ack cycle
  always_ff @(posedge wb_clk_i) begin
    if (rd) begin
      case (adr)
        irqc_pkg::reg_irqc_flag: dat_o <= {{(irqc_pkg::data_w-irqc_pkg::flag_w){1'b0}}, irq_flag};
        irqc_pkg::reg_irqc_mask: dat_o <= {{(irqc_pkg::data_w-irqc_pkg::flag_w){1'b0}}, irq_mask};
        default:                 dat_o <= '0;
      endcase
    end else if (sel_i) begin
      dat_o <= '0;
    end
  end

  assign irq_o = |(irq_flag & irq_mask);

endmodule

/* logic/irq_timer.sv */
// programmable interval timer with one-cycle expiry event
`timescale 1ns/1ps

module irq_timer (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  input  logic                       sel_i,
  input  logic                       wb_we_i,
  input  logic [irqc_pkg::data_w-1:0] wb_adr_i,
  input  logic [irqc_pkg::data_w-1:0] wb_dat_i,
  output logic                       ack_o,
  output logic [irqc_pkg::data_w-1:0] dat_o,
  output logic                       tmr_evt_o
);

  logic [irqc_pkg::data_w-1:0] load_q;
  logic [irqc_pkg::data_w-1:0] count_q;
  logic [irqc_pkg::ctrl_w-1:0] ctrl_q;
  logic                        expire;
  logic                        ctrl_wr;
  irqc_pkg::reg_addr_e         adr;

  assign adr     = irqc_pkg::reg_addr_e'(wb_adr_i);
  assign ctrl_wr = sel_i & wb_we_i & (adr == irqc_pkg::reg_tmr_ctrl);
  assign expire  = ctrl_q[irqc_pkg::ctrl_en] & (count_q == '0);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      load_q    <= '0;
      count_q   <= '0;
      ctrl_q    <= '0;
      tmr_evt_o <= 1'b0;
      ack_o     <= 1'b0;
    end else begin
      ack_o     <= sel_i;
      tmr_evt_o <= expire;
      if (sel_i && wb_we_i && adr == irqc_pkg::reg_tmr_load) begin
        load_q <= wb_dat_i;
      end
      if (ctrl_wr) begin
        ctrl_q <= wb_dat_i[irqc_pkg::ctrl_w-1:0];
        if (wb_dat_i[irqc_pkg::ctrl_en]) begin
          count_q <= load_q;   // start from the load value
        end
      end else if (expire) begin
        if (ctrl_q[irqc_pkg::ctrl_reload]) begin
          count_q <= load_q;
        end else begin
          ctrl_q[irqc_pkg::ctrl_en] <= 1'b0;   // one shot
        end
      end else if (ctrl_q[irqc_pkg::ctrl_en]) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (sel_i) begin
      case (adr)
        irqc_pkg::reg_tmr_load:  dat_o <= wb_we_i ? '0 : load_q;
        irqc_pkg::reg_tmr_ctrl:
          dat_o <= wb_we_i ? '0 : {{(irqc_pkg::data_w-irqc_pkg::ctrl_w){1'b0}}, ctrl_q};
        irqc_pkg::reg_tmr_count: dat_o <= wb_we_i ? '0 : count_q;
        default:                 dat_o <= '0;
      endcase
    end
  end

endmodule

/* logic/wb_resp_mux.sv */
// merges slave acks and steers the acking slave's read data onto the bus
`timescale 1ns/1ps

module wb_resp_mux (
  input  logic                       irqc_ack_i,
  input  logic [irqc_pkg::data_w-1:0] irqc_dat_i,
  input  logic                       tmr_ack_i,
  input  logic [irqc_pkg::data_w-1:0] tmr_dat_i,
  input  logic                       nomap_ack_i,
  output logic                       wb_ack_o,
  output logic [irqc_pkg::data_w-1:0] wb_dat_o
);

  assign wb_ack_o = irqc_ack_i | tmr_ack_i | nomap_ack_i;

  // at most one slave acks in a cycle
  always_comb begin
    if (irqc_ack_i) begin
      wb_dat_o = irqc_dat_i;
    end else if (tmr_ack_i) begin
      wb_dat_o = tmr_dat_i;
    end else begin
      wb_dat_o = '0;   // unmapped or idle
    end
  end

endmodule

/* logic/irq_subsys_top.sv */
// Wishbone interrupt subsystem top with event sync, controller and timer
`timescale 1ns/1ps

module irq_subsys_top (
  input  logic                        wb_clk_i,
  input  logic                        wb_rst_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [irqc_pkg::data_w-1:0]  wb_adr_i,
  input  logic [irqc_pkg::data_w-1:0]  wb_dat_i,
  input  logic [irqc_pkg::num_ext-1:0] ext_irq_i,
  output logic [irqc_pkg::data_w-1:0]  wb_dat_o,
  output logic                        wb_ack_o,
  output logic                        irq_o
);

  logic [irqc_pkg::num_ext-1:0] ext_evt;
  logic [irqc_pkg::num_src-1:0] src_evt;
  logic                         tmr_evt;
  logic                         irqc_sel;
  logic                         tmr_sel;
  logic                         nomap_ack;
  logic                         irqc_ack;
  logic                         tmr_ack;
  logic [irqc_pkg::data_w-1:0]  irqc_dat;
  logic [irqc_pkg::data_w-1:0]  tmr_dat;

  // timer sits above the external lines
  assign src_evt[irqc_pkg::num_ext-1:0] = ext_evt;
  assign src_evt[irqc_pkg::tmr_src]     = tmr_evt;

  event_sync event_sync_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .ext_irq_i (ext_irq_i),
    .ext_evt_o (ext_evt)
  );

  wb_decode wb_decode_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_adr_i    (wb_adr_i),
    .wb_ack_i    (wb_ack_o),   // bus ack fed back
    .irqc_sel_o  (irqc_sel),
    .tmr_sel_o   (tmr_sel),
    .nomap_ack_o (nomap_ack)
  );

  irq_controller irq_controller_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .sel_i    (irqc_sel),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .evt_i    (src_evt),
    .ack_o    (irqc_ack),
    .dat_o    (irqc_dat),
    .irq_o    (irq_o)
  );

  irq_timer irq_timer_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .sel_i     (tmr_sel),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .ack_o     (tmr_ack),
    .dat_o     (tmr_dat),
    .tmr_evt_o (tmr_evt)
  );

  wb_resp_mux wb_resp_mux_i (
    .irqc_ack_i  (irqc_ack),
    .irqc_dat_i  (irqc_dat),
    .tmr_ack_i   (tmr_ack),
    .tmr_dat_i   (tmr_dat),
    .nomap_ack_i (nomap_ack),
    .wb_ack_o    (wb_ack_o),
    .wb_dat_o    (wb_dat_o)
  );

endmodule

/* sim/irq_subsys_chk.sv */
// bound checker for the Wishbone ack rules and the interrupt line out of reset
`timescale 1ns/1ps

module irq_subsys_chk (
  input logic clk_i,
  input logic rst_i,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic irq_i
);

  int fail_cnt = 0;

  ack_single: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
    else begin
      fail_cnt++;
      $error("wb_ack_o high for two cycles in a row");
    end

  // ack only after a strobed cycle
  ack_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
                                  ack_i |-> $past(cyc_i && stb_i))
    else begin
      fail_cnt++;
      $error("wb_ack_o without a strobed cycle before it");
    end

  irq_after_rst: assert property (@(posedge clk_i) rst_i |=> !irq_i)
    else begin
      fail_cnt++;
      $error("irq_o high in the cycle after reset");
    end

endmodule

bind irq_subsys_top irq_subsys_chk irq_subsys_chk_i (
  .clk_i (wb_clk_i),
  .rst_i (wb_rst_i),
  .cyc_i (wb_cyc_i),
  .stb_i (wb_stb_i),
  .ack_i (wb_ack_o),
  .irq_i (irq_o)
);

/* sim/irq_subsys_tb.sv */
// vector-driven testbench for the Wishbone interrupt subsystem
`timescale 1ns/1ps

module irq_subsys_tb;

  localparam int row_w    = 5;    // test, op, address, data, expected
  localparam int max_rows = 64;
  localparam int ack_wait = 16;
  localparam int irq_wait = 400;

  localparam logic [15:0] op_end   = 16'h0000;
  localparam logic [15:0] op_write = 16'h0001;
  localparam logic [15:0] op_read  = 16'h0002;
  localparam logic [15:0] op_ext   = 16'h0003;
  localparam logic [15:0] op_irq   = 16'h0004;
  localparam logic [15:0] op_le    = 16'h0005;   // read against an upper bound

  logic                         wb_clk;
  logic                         wb_rst;
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic [irqc_pkg::data_w-1:0]  wb_adr;
  logic [irqc_pkg::data_w-1:0]  wb_wdat;
  logic [irqc_pkg::data_w-1:0]  wb_rdat;
  logic                         wb_ack;
  logic [irqc_pkg::num_ext-1:0] ext_irq;
  logic                         irq;

  logic [15:0] vec [0:row_w*max_rows-1];
  integer      seed;
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;

  irq_subsys_top irq_subsys_top_i (
    .wb_clk_i  (wb_clk),
    .wb_rst_i  (wb_rst),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_we_i   (wb_we),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_wdat),
    .ext_irq_i (ext_irq),
    .wb_dat_o  (wb_rdat),
    .wb_ack_o  (wb_ack),
    .irq_o     (irq)
  );

  always #2 wb_clk = ~wb_clk;

  task automatic count_check(input logic good);
    checks++;
    test_checks++;
    if (!good) begin
      errors++;
      test_errors++;
    end
  endtask

  // entered and left on a falling edge
  task automatic bus_access(input logic we, input logic [15:0] adr, input logic [15:0] dat,
                            output logic [15:0] rdat, output logic ok);
    int n;
    n      = 0;
    ok     = 1'b0;
    rdat   = '0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_wdat = dat;
    while (!ok && n < ack_wait) begin
      @(negedge wb_clk);
      n++;
      if (wb_ack) begin
        ok   = 1'b1;
        rdat = wb_rdat;   // data valid in the ack cycle
      end
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!ok) begin
      $display("no bus ack within %0d cycles for address %h", ack_wait, adr);
      count_check(1'b0);
    end
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (irq !== level && n < irq_wait) begin
      @(negedge wb_clk);
      n++;
    end
    if (irq !== level) begin
      $display("irq_o did not reach %0d within %0d cycles", level, irq_wait);
    end
    count_check(irq === level);
  endtask

  task automatic run_row(input logic [15:0] op, input logic [15:0] adr,
                         input logic [15:0] dat, input logic [15:0] exp);
    logic [15:0] rdat;
    logic        ok;
    int          gap;
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) @(negedge wb_clk);
    case (op)
      op_write: bus_access(1'b1, adr, dat, rdat, ok);
      op_read: begin
        bus_access(1'b0, adr, '0, rdat, ok);
        if (ok && rdat !== exp) begin
          $display("error wb_dat_o: got %h expected %h at address %h", rdat, exp, adr);
        end
        if (ok) count_check(rdat === exp);
      end
      op_le: begin
        bus_access(1'b0, adr, '0, rdat, ok);
        if (ok && rdat > exp) begin
          $display("error wb_dat_o: got %h expected at most %h at address %h", rdat, exp, adr);
        end
        if (ok) count_check(rdat <= exp);
      end
      op_ext:  ext_irq = dat[irqc_pkg::num_ext-1:0];
      op_irq:  wait_irq(exp[0]);
      default: begin
        $display("unknown vector operation %h", op);
        count_check(1'b0);
      end
    endcase
  endtask

  task automatic report_test(input int id);
    $display("test %0d done: %0d checks, %0d errors", id, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin
    int          row;
    int          assert_fails;
    logic [15:0] cur_test;
    wb_clk      = 1'b0;
    wb_rst      = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_wdat     = '0;
    ext_irq     = '0;
    seed        = 32'hac1f02f1;
    checks      = 0;
    errors      = 0;
    test_checks = 0;
    test_errors = 0;
    $readmemh("sim/irq_vectors.txt", vec);
    repeat (16) @(posedge wb_clk);
    @(negedge wb_clk);
    wb_rst   = 1'b0;
    row      = 0;
    cur_test = vec[0];
    while (row < max_rows && vec[row*row_w+1] != op_end) begin
      if (vec[row*row_w] != cur_test) begin
        report_test(cur_test);
        cur_test = vec[row*row_w];
      end
      run_row(vec[row*row_w+1], vec[row*row_w+2], vec[row*row_w+3], vec[row*row_w+4]);
      row++;
    end
    report_test(cur_test);
    assert_fails = irq_subsys_top_i.irq_subsys_chk_i.fail_cnt;
    if (assert_fails != 0) begin
      $display("%0d assertions failed in the bound checker", assert_fails);
      errors += assert_fails;
    end
    $display("done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* sim/irq_vectors.txt */
// columns: test op address data expected, all hex
// op 1 write, 2 read, 3 drive external lines, 4 wait irq_o, 5 read at most, 0 end
1 2 0004 0000 001f
1 2 0000 0000 0000
1 4 0000 0000 0000
2 3 0000 0001 0000
2 4 0000 0000 0001
2 2 0000 0000 0001
2 1 0004 001e 0000
2 4 0000 0000 0000
2 2 0000 0000 0001
3 3 0000 0000 0000
3 1 0004 001f 0000
3 1 0000 0000 0000
3 3 0000 0006 0000
3 4 0000 0000 0001
3 2 0000 0000 0006
3 1 0000 001b 0000
3 2 0000 0000 0002
3 1 0000 0000 0000
3 4 0000 0000 0000
4 1 0002 ffff 0000
4 4 0000 0000 0001
4 2 0000 0000 0010
4 1 0002 1234 0000
4 4 0000 0000 0000
4 2 0000 0000 0000
5 1 0004 0008 0000
5 1 0010 0020 0000
5 1 0012 0003 0000
5 5 0014 0000 0020
5 4 0000 0000 0001
5 2 0000 0000 0008
5 1 0000 0000 0000
5 4 0000 0000 0001
5 2 0000 0000 0008
6 1 0100 abcd 0000
6 2 0100 0000 0000
6 2 8000 0000 0000
0 0 0000 0000 0000

/* build.f */
logic/irqc_pkg.sv
logic/event_sync.sv
logic/wb_decode.sv
logic/irq_controller.sv
logic/irq_timer.sv
logic/wb_resp_mux.sv
logic/irq_subsys_top.sv
sim/irq_subsys_chk.sv
sim/irq_subsys_tb.sv

/* Makefile */
TOP = irq_subsys_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
